/* source/readout_pkg.sv */
`default_nettype none

package readout_pkg;

    typedef struct packed {
        logic [30:0] hit;    // raw front-end hit word
    } fe_word_t;

    typedef struct packed {
        logic [30:0] number;    // trigger number, first trigger is 1
    } trig_word_t;

    typedef struct packed {
        logic        tag;    // 1 trigger, 0 front end
        logic [30:0] payload;
    } out_word_t;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    // upper address byte selects the page
    localparam logic [7:0] TRIG_BASE    = 8'h00;
    localparam logic [7:0] READOUT_BASE = 8'h01;

    localparam logic [7:0] TRIG_CTRL   = 8'd0;
    localparam logic [7:0] TRIG_CLEAR  = 8'd1;
    localparam logic [7:0] TRIG_COUNT0 = 8'd2;
    localparam logic [7:0] TRIG_COUNT1 = 8'd3;
    localparam logic [7:0] TRIG_COUNT2 = 8'd4;
    localparam logic [7:0] TRIG_COUNT3 = 8'd5;
    localparam logic [7:0] TRIG_DROPS  = 8'd6;

    localparam logic [7:0] RO_STATUS   = 8'd0;
    localparam logic [7:0] RO_DATA0    = 8'd1;
    localparam logic [7:0] RO_DATA1    = 8'd2;
    localparam logic [7:0] RO_DATA2    = 8'd3;
    localparam logic [7:0] RO_DATA3    = 8'd4;    // read pops the head word
    localparam logic [7:0] RO_FE_DROPS = 8'd5;

endpackage

`default_nettype wire

/* source/reg_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface reg_bus_if;

    logic [7:0] add;         // offset within the page
    logic [7:0] data_in;
    logic       wr;
    logic       rd;
    logic [7:0] data_out;    // combinational read data

    modport master (
        output add, data_in, wr, rd,
        input  data_out
    );

    modport slave (
        input  add, data_in, wr, rd,
        output data_out
    );

endinterface

`default_nettype wire

/* source/word_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module word_fifo #(
    parameter type payload_t = logic [30:0]
) (
    input  logic       BUS_CLK,
    input  logic       reset,
    input  logic       push,
    input  payload_t   push_data,
    input  logic       pop,
    output payload_t   head,
    output logic       empty,
    output logic       full,
    output logic [7:0] drops
);

    payload_t mem [readout_pkg::FIFO_DEPTH];

    logic [readout_pkg::FIFO_AW-1:0] wr_ptr;
    logic [readout_pkg::FIFO_AW-1:0] rd_ptr;
    logic [readout_pkg::FIFO_AW:0]   count;
    logic do_push;
    logic do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (readout_pkg::FIFO_AW + 1)'(readout_pkg::FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;    // pop on empty is ignored
    assign head    = mem[rd_ptr];

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drops  <= 8'd0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full && drops != 8'hff)
                drops <= drops + 8'd1;    // saturating drop count
        end
    end

endmodule

`default_nettype wire

/* source/trigger_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module trigger_unit (
    input  logic                     BUS_CLK,
    input  logic                     reset,
    input  logic                     trigger_in,
    input  logic                     veto_in,
    input  logic                     enable,
    input  logic                     veto_enable,
    input  logic                     clear,
    output logic                     push,
    output readout_pkg::trig_word_t  trig_word,
    output logic [30:0]              trig_number
);

    logic trig_s;    // sample register
    logic trig_d;    // edge register
    logic veto_s;
    logic rise;
    logic accept;
    logic [30:0] number;

    assign rise   = trig_s && !trig_d;
    // vetoed edges are lost, not delayed
    assign accept = rise && enable && !(veto_enable && veto_s);

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            trig_s <= 1'b0;
            trig_d <= 1'b0;
            veto_s <= 1'b0;
        end else begin
            trig_s <= trigger_in;
            trig_d <= trig_s;
            veto_s <= veto_in;    // sampled alongside the trigger
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            number <= 31'd0;
            push   <= 1'b0;
        end else begin
            push <= 1'b0;
            if (clear) begin
                number <= 31'd0;
            end else if (accept) begin
                number <= number + 31'd1;
                push   <= 1'b1;    // word follows the increment
            end
        end
    end

    // number already holds the new value while push is high
    assign trig_word.number = number;
    assign trig_number      = number;

endmodule

`default_nettype wire

/* source/trigger_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module trigger_regs (
    input  logic        BUS_CLK,
    input  logic        reset,
    reg_bus_if.slave    bus,
    output logic        enable,
    output logic        veto_enable,
    output logic        clear,
    input  logic [30:0] trig_number,
    input  logic [7:0]  trig_drops
);

    logic [1:0]  ctrl;
    logic [31:0] count_word;

    assign enable      = ctrl[0];
    assign veto_enable = ctrl[1];
    assign count_word  = {1'b0, trig_number};

    // clear acts at the same edge as the write
    assign clear = bus.wr && (bus.add == readout_pkg::TRIG_CLEAR);

    always_ff @(posedge BUS_CLK) begin
        if (reset)
            ctrl <= 2'b00;
        else if (bus.wr && bus.add == readout_pkg::TRIG_CTRL)
            ctrl <= bus.data_in[1:0];
    end

    always_comb begin
        case (bus.add)
            readout_pkg::TRIG_CTRL:   bus.data_out = {6'd0, ctrl};
            readout_pkg::TRIG_COUNT0: bus.data_out = count_word[7:0];
            readout_pkg::TRIG_COUNT1: bus.data_out = count_word[15:8];
            readout_pkg::TRIG_COUNT2: bus.data_out = count_word[23:16];
            readout_pkg::TRIG_COUNT3: bus.data_out = count_word[31:24];
            readout_pkg::TRIG_DROPS:  bus.data_out = trig_drops;
            default:                  bus.data_out = 8'd0;    // clear reads zero too
        endcase
    end

endmodule

`default_nettype wire

/* source/stream_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_arbiter (
    input  logic                    BUS_CLK,
    input  logic                    reset,
    input  readout_pkg::fe_word_t   fe_head,
    input  logic                    fe_empty,
    output logic                    fe_pop,
    input  readout_pkg::trig_word_t trig_head,
    input  logic                    trig_empty,
    output logic                    trig_pop,
    output readout_pkg::out_word_t  out_head,
    output logic                    out_valid,
    input  logic                    out_pop
);

    logic grant_trig;    // 1 while the trigger queue owns the output

    assign fe_pop   = out_pop && !grant_trig && !fe_empty;
    assign trig_pop = out_pop && grant_trig && !trig_empty;

    /*
     * trigger words slip in behind a front-end word, or whenever
     * the front-end queue runs dry; one trigger word per grant
     */
    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            grant_trig <= 1'b0;
        end else if (grant_trig && trig_pop) begin
            grant_trig <= 1'b0;    // back to front end
        end else if (!trig_empty && (fe_empty || fe_pop)) begin
            grant_trig <= 1'b1;
        end
    end

    assign out_valid = grant_trig ? !trig_empty : !fe_empty;

    assign out_head.tag     = grant_trig;
    assign out_head.payload = grant_trig ? trig_head.number : fe_head.hit;

endmodule

`default_nettype wire

/* source/readout_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module readout_regs (
    input  logic                   BUS_CLK,
    input  logic                   reset,
    reg_bus_if.slave               bus,
    input  readout_pkg::out_word_t out_head,
    input  logic                   out_valid,
    output logic                   out_pop,
    input  logic [7:0]             fe_drops
);

    logic [31:0] head_bits;
    logic        last_byte_rd;

    assign head_bits = out_head;

    // reading the top byte of a valid word consumes it
    assign last_byte_rd = bus.rd && (bus.add == readout_pkg::RO_DATA3) && out_valid;

    // pop lands one cycle after the read so the head stays stable until then
    always_ff @(posedge BUS_CLK) begin
        if (reset)
            out_pop <= 1'b0;
        else
            out_pop <= last_byte_rd;
    end

    always_comb begin
        case (bus.add)
            readout_pkg::RO_STATUS:   bus.data_out = {7'd0, out_valid && !out_pop};
            readout_pkg::RO_DATA0:    bus.data_out = head_bits[7:0];
            readout_pkg::RO_DATA1:    bus.data_out = head_bits[15:8];
            readout_pkg::RO_DATA2:    bus.data_out = head_bits[23:16];
            readout_pkg::RO_DATA3:    bus.data_out = head_bits[31:24];    // tag in bit 7
            readout_pkg::RO_FE_DROPS: bus.data_out = fe_drops;
            default:                  bus.data_out = 8'd0;
        endcase
    end

endmodule

`default_nettype wire

/* source/readout_top.sv */
`timescale 1ns/100ps
`default_nettype none

module readout_top (
    input  logic        BUS_CLK,
    input  logic        reset,
    input  logic [15:0] add,
    input  logic [7:0]  data_in,
    input  logic        wr,
    input  logic        rd,
    output logic [7:0]  data_out,
    input  logic [30:0] fe_data,
    input  logic        fe_valid,
    input  logic        trigger_in,
    input  logic        veto_in
);

    reg_bus_if trig_bus ();
    reg_bus_if ro_bus ();

    logic trig_sel;
    logic ro_sel;

    readout_pkg::fe_word_t   fe_word;
    readout_pkg::fe_word_t   fe_head;
    readout_pkg::trig_word_t trig_word;
    readout_pkg::trig_word_t trig_head;
    readout_pkg::out_word_t  out_head;

    logic fe_pop, fe_empty;
    logic trig_push, trig_pop, trig_empty;
    logic out_valid, out_pop;
    logic enable, veto_enable, trig_clear;
    logic [30:0] trig_number;
    logic [7:0]  fe_drops, trig_drops;

    // page decode on the upper address byte
    assign trig_sel = (add[15:8] == readout_pkg::TRIG_BASE);
    assign ro_sel   = (add[15:8] == readout_pkg::READOUT_BASE);

    assign trig_bus.add     = add[7:0];
    assign trig_bus.data_in = data_in;
    assign trig_bus.wr      = wr && trig_sel;
    assign trig_bus.rd      = rd && trig_sel;

    assign ro_bus.add     = add[7:0];
    assign ro_bus.data_in = data_in;
    assign ro_bus.wr      = wr && ro_sel;
    assign ro_bus.rd      = rd && ro_sel;

    always_comb begin
        if (trig_sel)
            data_out = trig_bus.data_out;
        else if (ro_sel)
            data_out = ro_bus.data_out;
        else
            data_out = 8'd0;    // unmapped page
    end

    assign fe_word.hit = fe_data;

    word_fifo #(.payload_t(readout_pkg::fe_word_t)) fe_fifo (
        .BUS_CLK(BUS_CLK), .reset(reset),
        .push(fe_valid), .push_data(fe_word), .pop(fe_pop),
        .head(fe_head), .empty(fe_empty), .full(), .drops(fe_drops)
    );

    word_fifo #(.payload_t(readout_pkg::trig_word_t)) trig_fifo (
        .BUS_CLK(BUS_CLK), .reset(reset),
        .push(trig_push), .push_data(trig_word), .pop(trig_pop),
        .head(trig_head), .empty(trig_empty), .full(), .drops(trig_drops)
    );

    trigger_unit trig_unit (
        .BUS_CLK(BUS_CLK), .reset(reset),
        .trigger_in(trigger_in), .veto_in(veto_in),
        .enable(enable), .veto_enable(veto_enable), .clear(trig_clear),
        .push(trig_push), .trig_word(trig_word), .trig_number(trig_number)
    );

    trigger_regs trig_regs (
        .BUS_CLK(BUS_CLK), .reset(reset), .bus(trig_bus.slave),
        .enable(enable), .veto_enable(veto_enable), .clear(trig_clear),
        .trig_number(trig_number), .trig_drops(trig_drops)
    );

    stream_arbiter arbiter (
        .BUS_CLK(BUS_CLK), .reset(reset),
        .fe_head(fe_head), .fe_empty(fe_empty), .fe_pop(fe_pop),
        .trig_head(trig_head), .trig_empty(trig_empty), .trig_pop(trig_pop),
        .out_head(out_head), .out_valid(out_valid), .out_pop(out_pop)
    );

    readout_regs ro_regs (
        .BUS_CLK(BUS_CLK), .reset(reset), .bus(ro_bus.slave),
        .out_head(out_head), .out_valid(out_valid), .out_pop(out_pop),
        .fe_drops(fe_drops)
    );

endmodule

`default_nettype wire

/* testbench/tb_readout_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_readout_top;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_FE, OP_TRIG, OP_IDLE, OP_POP} op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] arg;         // bus address, cycle count or word count
        logic [7:0]  data;        // write data or the veto bit of a trigger
        logic [31:0] expected;    // read value, trigger number or fe keep flag
    } step_t;

    logic        BUS_CLK = 1'b0;
    logic        reset;
    logic [15:0] add;
    logic [7:0]  data_in;
    logic        wr;
    logic        rd;
    logic [7:0]  data_out;
    logic [30:0] fe_data;
    logic        fe_valid;
    logic        trigger_in;
    logic        veto_in;

    step_t       steps[$];
    logic [30:0] fe_model[$];      // expected front-end payloads in order
    logic [30:0] trig_model[$];    // expected trigger numbers in order
    integer      seed = 32'h9525a68a;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    readout_top uut (
        .BUS_CLK(BUS_CLK), .reset(reset),
        .add(add), .data_in(data_in), .wr(wr), .rd(rd), .data_out(data_out),
        .fe_data(fe_data), .fe_valid(fe_valid),
        .trigger_in(trigger_in), .veto_in(veto_in)
    );

    always #5 BUS_CLK = ~BUS_CLK;

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    // cycle watchdog with a limit taken from the step table
    always @(posedge BUS_CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            stop_run();
        end
    end

    function automatic logic [15:0] trig_addr(input logic [7:0] offset);
        return {readout_pkg::TRIG_BASE, offset};
    endfunction

    function automatic logic [15:0] ro_addr(input logic [7:0] offset);
        return {readout_pkg::READOUT_BASE, offset};
    endfunction

    task automatic add_step(input op_t op, input logic [15:0] arg, input logic [7:0] data,
                            input logic [31:0] expected);
        steps.push_back('{op, arg, data, expected});
    endtask

    // strobes drop back to idle on each falling edge
    task automatic next_cycle();
        @(negedge BUS_CLK);
        wr         = 1'b0;
        rd         = 1'b0;
        fe_valid   = 1'b0;
        trigger_in = 1'b0;
        veto_in    = 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] value);
        next_cycle();
        add     = addr;
        data_in = value;
        wr      = 1'b1;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] value);
        next_cycle();
        add = addr;
        rd  = 1'b1;
        #1 value = data_out;    // read data settles well before the rising edge
    endtask

    task automatic send_fe(input logic [30:0] value);
        next_cycle();
        fe_data  = value;
        fe_valid = 1'b1;
    endtask

    // one-cycle pulse plus three cycles for the word to reach the queue
    task automatic pulse_trigger(input logic veto);
        next_cycle();
        trigger_in = 1'b1;
        veto_in    = veto;
        repeat (3) next_cycle();
    endtask

    task automatic read_word();
        logic [7:0]  status;
        logic [7:0]  b0, b1, b2, b3;
        logic [31:0] word;
        status = 8'd0;
        while (status[0] !== 1'b1)
            bus_read(ro_addr(readout_pkg::RO_STATUS), status);
        bus_read(ro_addr(readout_pkg::RO_DATA0), b0);
        bus_read(ro_addr(readout_pkg::RO_DATA1), b1);
        bus_read(ro_addr(readout_pkg::RO_DATA2), b2);
        bus_read(ro_addr(readout_pkg::RO_DATA3), b3);
        word = {b3, b2, b1, b0};
        if (word[31]) begin
            if (trig_model.size() == 0) begin
                $display("a trigger word %h came out when none was expected", word);
                stop_run();
            end else begin
                check("trigger word", word, {1'b1, trig_model.pop_front()});
            end
        end else begin
            if (fe_model.size() == 0) begin
                $display("a front-end word %h came out when none was expected", word);
                stop_run();
            end else begin
                check("front-end word", word, {1'b0, fe_model.pop_front()});
            end
        end
    endtask

    task automatic apply_step(input step_t s);
        logic [7:0]  value;
        logic [30:0] hit;
        case (s.op)
            OP_WRITE: bus_write(s.arg, s.data);
            OP_READ: begin
                bus_read(s.arg, value);
                check($sformatf("data_out at %h", s.arg), {24'd0, value}, s.expected);
            end
            OP_FE: begin
                hit = 31'($random(seed));
                send_fe(hit);
                if (s.expected[0])
                    fe_model.push_back(hit);    // dropped words stay out of the model
            end
            OP_TRIG: begin
                pulse_trigger(s.data[0]);
                if (s.expected != 0)
                    trig_model.push_back(s.expected[30:0]);
            end
            OP_IDLE: repeat (s.arg) next_cycle();
            default: repeat (s.arg) read_word();
        endcase
    endtask

    task automatic read_count(input logic [31:0] count);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_COUNT0), 8'd0, count[7:0]);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_COUNT1), 8'd0, count[15:8]);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_COUNT2), 8'd0, count[23:16]);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_COUNT3), 8'd0, count[31:24]);
    endtask

    task automatic build_steps();
        // reset state
        add_step(OP_READ, ro_addr(readout_pkg::RO_STATUS), 8'd0, 0);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_CTRL), 8'd0, 0);
        read_count(0);
        add_step(OP_READ, 16'h0200, 8'd0, 0);    // unmapped page
        add_step(OP_WRITE, trig_addr(readout_pkg::TRIG_CTRL), 8'd3, 0);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_CTRL), 8'd0, 3);
        // front-end words only
        repeat (5) add_step(OP_FE, 16'd0, 8'd0, 1);
        add_step(OP_POP, 16'd5, 8'd0, 0);
        add_step(OP_IDLE, 16'd4, 8'd0, 0);
        add_step(OP_READ, ro_addr(readout_pkg::RO_STATUS), 8'd0, 0);
        // triggers followed by disabled and vetoed pulses
        add_step(OP_TRIG, 16'd0, 8'd0, 1);
        add_step(OP_TRIG, 16'd0, 8'd0, 2);
        add_step(OP_TRIG, 16'd0, 8'd0, 3);
        read_count(3);
        add_step(OP_WRITE, trig_addr(readout_pkg::TRIG_CTRL), 8'd0, 0);
        add_step(OP_TRIG, 16'd0, 8'd0, 0);
        add_step(OP_WRITE, trig_addr(readout_pkg::TRIG_CTRL), 8'd3, 0);
        add_step(OP_TRIG, 16'd0, 8'd1, 0);
        read_count(3);
        add_step(OP_POP, 16'd3, 8'd0, 0);
        add_step(OP_WRITE, trig_addr(readout_pkg::TRIG_CLEAR), 8'd0, 0);
        read_count(0);
        // interleaved sources
        add_step(OP_WRITE, trig_addr(readout_pkg::TRIG_CTRL), 8'd1, 0);
        add_step(OP_FE, 16'd0, 8'd0, 1);
        add_step(OP_IDLE, 16'd2, 8'd0, 0);
        add_step(OP_TRIG, 16'd0, 8'd0, 1);
        add_step(OP_FE, 16'd0, 8'd0, 1);
        add_step(OP_FE, 16'd0, 8'd0, 1);
        add_step(OP_TRIG, 16'd0, 8'd0, 2);
        add_step(OP_IDLE, 16'd3, 8'd0, 0);
        add_step(OP_FE, 16'd0, 8'd0, 1);
        add_step(OP_TRIG, 16'd0, 8'd0, 3);
        add_step(OP_POP, 16'd7, 8'd0, 0);
        add_step(OP_IDLE, 16'd4, 8'd0, 0);
        add_step(OP_READ, ro_addr(readout_pkg::RO_STATUS), 8'd0, 0);
        // overflow of the front-end queue
        for (int i = 0; i < 20; i++)
            add_step(OP_FE, 16'd0, 8'd0, (i < readout_pkg::FIFO_DEPTH) ? 1 : 0);
        add_step(OP_READ, ro_addr(readout_pkg::RO_FE_DROPS), 8'd0, 4);
        add_step(OP_READ, trig_addr(readout_pkg::TRIG_DROPS), 8'd0, 0);
        add_step(OP_POP, 16'd16, 8'd0, 0);
        add_step(OP_IDLE, 16'd4, 8'd0, 0);
        add_step(OP_READ, ro_addr(readout_pkg::RO_STATUS), 8'd0, 0);
    endtask

    initial begin
        reset      = 1'b1;
        add        = 16'd0;
        data_in    = 8'd0;
        wr         = 1'b0;
        rd         = 1'b0;
        fe_data    = 31'd0;
        fe_valid   = 1'b0;
        trigger_in = 1'b0;
        veto_in    = 1'b0;
        build_steps();
        cycle_limit = 10 * steps.size() + 100;
        repeat (16) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        reset = 1'b0;
        foreach (steps[i])
            apply_step(steps[i]);
        next_cycle();
        if (fe_model.size() != 0 || trig_model.size() != 0) begin
            $display("%0d front-end and %0d trigger words never came out",
                     fe_model.size(), trig_model.size());
            stop_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* readout_top.f */
source/readout_pkg.sv
source/reg_bus_if.sv
source/word_fifo.sv
source/trigger_unit.sv
source/trigger_regs.sv
source/stream_arbiter.sv
source/readout_regs.sv
source/readout_top.sv
testbench/tb_readout_top.sv

/* Makefile */
# Verilator flow for the readout block

VERILATOR ?= verilator
TOP       ?= tb_readout_top
RTL_TOP   ?= readout_top
FILELIST  ?= readout_top.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --timescale $(TIMESCALE)
PASS_MSG  ?= test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
